/* alu_pkg.sv */
/*
  alu_pkg
  shared width, RV64I opcode and funct encodings, instruction word views,
  decoded control and registered result types of the integer execution unit
*/
package alu_pkg;

  // data and address width
  localparam int unsigned xlen = 64;

  // major opcodes kept by the unit
  localparam logic [6:0] op        = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_32     = 7'b0111011;
  localparam logic [6:0] op_imm_32 = 7'b0011011;
  localparam logic [6:0] auipc     = 7'b0010111;
  localparam logic [6:0] branch    = 7'b1100011;
  localparam logic [6:0] jal       = 7'b1101111;
  localparam logic [6:0] jalr      = 7'b1100111;

  // funct3 for OP / OP-IMM and word forms
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // only legal funct3 of jalr
  localparam logic [2:0] f3_jalr = 3'b000;

  // funct7, base ops and sub / arithmetic shift
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // B immediate is scattered over the word
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, five readings
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    u_fmt_t u_fmt;
    b_fmt_t b_fmt;
    j_fmt_t j_fmt;
  } insn_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_srl, alu_sra,
    alu_slt, alu_sltu, alu_xor, alu_or, alu_and
  } alu_op_t;

  typedef enum logic [2:0] {
    cmp_eq, cmp_ne, cmp_lt, cmp_ge, cmp_ltu, cmp_geu
  } cmp_op_t;

  typedef struct packed {
    alu_op_t             alu_op;
    cmp_op_t             cmp_op;
    logic                use_imm;
    logic                use_pc;
    logic                word;
    logic                writes_dest;
    logic                is_branch;
    logic                is_jal;
    logic                is_jalr;
    logic [xlen-1:0]     imm;
  } decoded_t;

  typedef struct packed {
    logic            dest_enable;
    logic            dest_long;
    logic [xlen-1:0] dest;
    logic            branch_target_enable;
    logic [xlen-1:0] branch_target;
  } result_t;

endpackage

/* insn_decode.sv */
/*
  insn_decode
  matches opcode and funct fields of the kept RV64I subset and builds the
  control struct with the sign-extended immediate of the matching format
*/
`timescale 1ns/100ps

module insn_decode (
  input  alu_pkg::insn_t    insn,
  output alu_pkg::decoded_t dec
);

  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic [alu_pkg::xlen-1:0] i_imm;
  logic [alu_pkg::xlen-1:0] u_imm;
  logic [alu_pkg::xlen-1:0] b_imm;
  logic [alu_pkg::xlen-1:0] j_imm;
  logic [alu_pkg::xlen-1:0] shamt_imm;
  logic                     imm_word;
  logic                     imm_sh_base;
  logic                     imm_sh_alt;

  assign opcode = insn.r_fmt.opcode;
  assign funct3 = insn.r_fmt.funct3;
  assign funct7 = insn.r_fmt.funct7;

  // immediates, all sign-extended to xlen
  assign i_imm = {{(alu_pkg::xlen-12){insn.i_fmt.imm_11_0[11]}}, insn.i_fmt.imm_11_0};
  assign u_imm = {{(alu_pkg::xlen-32){insn.u_fmt.imm_31_12[19]}},
                  insn.u_fmt.imm_31_12, 12'b0};
  assign b_imm = {{(alu_pkg::xlen-13){insn.b_fmt.imm_12}}, insn.b_fmt.imm_12,
                  insn.b_fmt.imm_11, insn.b_fmt.imm_10_5, insn.b_fmt.imm_4_1, 1'b0};
  assign j_imm = {{(alu_pkg::xlen-21){insn.j_fmt.imm_20}}, insn.j_fmt.imm_20,
                  insn.j_fmt.imm_19_12, insn.j_fmt.imm_11, insn.j_fmt.imm_10_1, 1'b0};

  // shift amount rides in the immediate, zero-extended
  assign shamt_imm = {{(alu_pkg::xlen-6){1'b0}}, insn.i_fmt.imm_11_0[5:0]};

  // rv64 immediate shifts have a 6-bit shamt so only funct7[6:1] counts,
  // word shifts keep the full funct7
  assign imm_word    = (opcode == alu_pkg::op_imm_32);
  assign imm_sh_base = imm_word ? (funct7 == alu_pkg::f7_base)
                                : (funct7[6:1] == alu_pkg::f7_base[6:1]);
  assign imm_sh_alt  = imm_word ? (funct7 == alu_pkg::f7_alt)
                                : (funct7[6:1] == alu_pkg::f7_alt[6:1]);

  always_comb begin
    // inactive unless an arm below recognizes the encoding
    dec        = '0;
    dec.alu_op = alu_pkg::alu_add;
    dec.cmp_op = alu_pkg::cmp_eq;
    case (opcode)
      alu_pkg::op, alu_pkg::op_32: begin
        dec.word        = (opcode == alu_pkg::op_32);
        dec.writes_dest = 1'b1;
        case ({funct7, funct3})
          {alu_pkg::f7_base, alu_pkg::f3_add_sub}: dec.alu_op = alu_pkg::alu_add;
          {alu_pkg::f7_alt,  alu_pkg::f3_add_sub}: dec.alu_op = alu_pkg::alu_sub;
          {alu_pkg::f7_base, alu_pkg::f3_sll}:     dec.alu_op = alu_pkg::alu_sll;
          {alu_pkg::f7_base, alu_pkg::f3_srl_sra}: dec.alu_op = alu_pkg::alu_srl;
          {alu_pkg::f7_alt,  alu_pkg::f3_srl_sra}: dec.alu_op = alu_pkg::alu_sra;
          // compares and logic have no word form
          {alu_pkg::f7_base, alu_pkg::f3_slt}: begin
            dec.alu_op      = alu_pkg::alu_slt;
            dec.writes_dest = !dec.word;
          end
          {alu_pkg::f7_base, alu_pkg::f3_sltu}: begin
            dec.alu_op      = alu_pkg::alu_sltu;
            dec.writes_dest = !dec.word;
          end
          {alu_pkg::f7_base, alu_pkg::f3_xor}: begin
            dec.alu_op      = alu_pkg::alu_xor;
            dec.writes_dest = !dec.word;
          end
          {alu_pkg::f7_base, alu_pkg::f3_or}: begin
            dec.alu_op      = alu_pkg::alu_or;
            dec.writes_dest = !dec.word;
          end
          {alu_pkg::f7_base, alu_pkg::f3_and}: begin
            dec.alu_op      = alu_pkg::alu_and;
            dec.writes_dest = !dec.word;
          end
          default: dec.writes_dest = 1'b0;
        endcase
      end
      alu_pkg::op_imm, alu_pkg::op_imm_32: begin
        dec.word        = imm_word;
        dec.use_imm     = 1'b1;
        dec.imm         = i_imm;
        dec.writes_dest = 1'b1;
        case (funct3)
          alu_pkg::f3_add_sub: dec.alu_op = alu_pkg::alu_add;
          alu_pkg::f3_slt: begin
            dec.alu_op      = alu_pkg::alu_slt;
            dec.writes_dest = !imm_word;
          end
          alu_pkg::f3_sltu: begin
            dec.alu_op      = alu_pkg::alu_sltu;
            dec.writes_dest = !imm_word;
          end
          alu_pkg::f3_xor: begin
            dec.alu_op      = alu_pkg::alu_xor;
            dec.writes_dest = !imm_word;
          end
          alu_pkg::f3_or: begin
            dec.alu_op      = alu_pkg::alu_or;
            dec.writes_dest = !imm_word;
          end
          alu_pkg::f3_and: begin
            dec.alu_op      = alu_pkg::alu_and;
            dec.writes_dest = !imm_word;
          end
          alu_pkg::f3_sll: begin
            dec.alu_op      = alu_pkg::alu_sll;
            dec.imm         = shamt_imm;
            dec.writes_dest = imm_sh_base;
          end
          alu_pkg::f3_srl_sra: begin
            dec.alu_op      = imm_sh_alt ? alu_pkg::alu_sra : alu_pkg::alu_srl;
            dec.imm         = shamt_imm;
            dec.writes_dest = imm_sh_base || imm_sh_alt;
          end
        endcase
      end
      alu_pkg::auipc: begin
        dec.use_pc      = 1'b1;
        dec.use_imm     = 1'b1;
        dec.imm         = u_imm;
        dec.writes_dest = 1'b1;
      end
      alu_pkg::branch: begin
        dec.imm       = b_imm;
        dec.is_branch = 1'b1;
        case (funct3)
          alu_pkg::f3_beq:  dec.cmp_op = alu_pkg::cmp_eq;
          alu_pkg::f3_bne:  dec.cmp_op = alu_pkg::cmp_ne;
          alu_pkg::f3_blt:  dec.cmp_op = alu_pkg::cmp_lt;
          alu_pkg::f3_bge:  dec.cmp_op = alu_pkg::cmp_ge;
          alu_pkg::f3_bltu: dec.cmp_op = alu_pkg::cmp_ltu;
          alu_pkg::f3_bgeu: dec.cmp_op = alu_pkg::cmp_geu;
          default:          dec.is_branch = 1'b0;
        endcase
      end
      alu_pkg::jal: begin
        dec.imm         = j_imm;
        dec.is_jal      = 1'b1;
        dec.writes_dest = 1'b1;
      end
      alu_pkg::jalr: begin
        dec.imm         = i_imm;
        dec.is_jalr     = (funct3 == alu_pkg::f3_jalr);
        dec.writes_dest = (funct3 == alu_pkg::f3_jalr);
      end
      default: ;
    endcase
  end

  // branches never write a register
  always_comb begin
    assert (!(dec.is_branch && dec.writes_dest))
      else $error("decoder set is_branch and writes_dest together");
  end

endmodule

/* int_alu.sv */
/*
  int_alu
  integer arithmetic, logic, shift and compare for 64-bit and word forms
*/
`timescale 1ns/100ps

module int_alu (
  input  alu_pkg::decoded_t        dec,
  input  logic [alu_pkg::xlen-1:0] pc,
  input  logic [alu_pkg::xlen-1:0] src1,
  input  logic [alu_pkg::xlen-1:0] src2,
  output logic [alu_pkg::xlen-1:0] result
);

  logic [alu_pkg::xlen-1:0] opa;
  logic [alu_pkg::xlen-1:0] opb;
  logic [5:0]               shamt;
  logic [alu_pkg::xlen-1:0] raw;

  // pc only for auipc
  assign opa = dec.use_pc ? pc : src1;
  assign opb = dec.use_imm ? dec.imm : src2;

  // word shifts use 5 bits of shift amount
  assign shamt = dec.word ? {1'b0, opb[4:0]} : opb[5:0];

  always_comb begin
    case (dec.alu_op)
      alu_pkg::alu_add: raw = opa + opb;
      alu_pkg::alu_sub: raw = opa - opb;
      // low bits of a left shift match in both widths
      alu_pkg::alu_sll: raw = opa << shamt;
      alu_pkg::alu_srl: begin
        if (dec.word)
          raw = {32'b0, opa[31:0]} >> shamt;
        else
          raw = opa >> shamt;
      end
      alu_pkg::alu_sra: begin
        // word form sign bit is bit 31
        if (dec.word)
          raw = $signed({{32{opa[31]}}, opa[31:0]}) >>> shamt;
        else
          raw = $signed(opa) >>> shamt;
      end
      alu_pkg::alu_slt:  raw = {{(alu_pkg::xlen-1){1'b0}}, $signed(opa) < $signed(opb)};
      alu_pkg::alu_sltu: raw = {{(alu_pkg::xlen-1){1'b0}}, opa < opb};
      alu_pkg::alu_xor:  raw = opa ^ opb;
      alu_pkg::alu_or:   raw = opa | opb;
      alu_pkg::alu_and:  raw = opa & opb;
      default:           raw = opa + opb;
    endcase
  end

  // word results sign-extend from bit 31
  assign result = dec.word ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

/* branch_unit.sv */
/*
  branch_unit
  branch condition, jump and branch targets, and the pc+4 link value
*/
`timescale 1ns/100ps

module branch_unit (
  input  alu_pkg::decoded_t        dec,
  input  logic [alu_pkg::xlen-1:0] pc,
  input  logic [alu_pkg::xlen-1:0] src1,
  input  logic [alu_pkg::xlen-1:0] src2,
  output logic                     taken,
  output logic [alu_pkg::xlen-1:0] target,
  output logic [alu_pkg::xlen-1:0] link
);

  logic                     is_eq;
  logic                     is_lt;
  logic                     is_ltu;
  logic                     cond;
  logic [alu_pkg::xlen-1:0] pc_rel;
  logic [alu_pkg::xlen-1:0] reg_rel;

  assign is_eq  = (src1 == src2);
  assign is_lt  = ($signed(src1) < $signed(src2));
  assign is_ltu = (src1 < src2);

  always_comb begin
    case (dec.cmp_op)
      alu_pkg::cmp_eq:  cond = is_eq;
      alu_pkg::cmp_ne:  cond = !is_eq;
      alu_pkg::cmp_lt:  cond = is_lt;
      alu_pkg::cmp_ge:  cond = !is_lt;
      alu_pkg::cmp_ltu: cond = is_ltu;
      alu_pkg::cmp_geu: cond = !is_ltu;
      default:          cond = 1'b0;
    endcase
  end

  // branches and jal are pc-relative
  assign pc_rel = pc + dec.imm;

  // jalr clears bit 0 of the sum
  assign reg_rel = (src1 + dec.imm) & ~{{(alu_pkg::xlen-1){1'b0}}, 1'b1};

  assign taken  = (dec.is_branch && cond) || dec.is_jal || dec.is_jalr;
  assign target = dec.is_jalr ? reg_rel : pc_rel;
  assign link   = pc + 64'd4;

  always_comb begin
    if (taken && dec.is_jalr)
      assert (!target[0]) else $error("odd jalr target selected");
  end

endmodule

/* core_alu.sv */
/*
  core_alu
  one-cycle RV64I execution unit, decodes the word, computes result and
  redirect, and holds them in one output register
*/
`timescale 1ns/100ps

module core_alu (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [31:0]              insn,
  input  logic [alu_pkg::xlen-1:0] pc,
  input  logic [alu_pkg::xlen-1:0] src1,
  input  logic [alu_pkg::xlen-1:0] src2,
  output logic                     dest_enable,
  output logic                     dest_long,
  output logic [alu_pkg::xlen-1:0] dest,
  output logic                     branch_target_enable,
  output logic [alu_pkg::xlen-1:0] branch_target
);

  alu_pkg::insn_t           insn_u;
  alu_pkg::decoded_t        dec;
  logic [alu_pkg::xlen-1:0] alu_result;
  logic                     taken;
  logic [alu_pkg::xlen-1:0] target;
  logic [alu_pkg::xlen-1:0] link;
  alu_pkg::result_t         res_d;
  alu_pkg::result_t         res_q;

  assign insn_u = alu_pkg::insn_t'(insn);

  insn_decode u_insn_decode (
    .insn (insn_u),
    .dec  (dec)
  );

  int_alu u_int_alu (
    .dec    (dec),
    .pc     (pc),
    .src1   (src1),
    .src2   (src2),
    .result (alu_result)
  );

  branch_unit u_branch_unit (
    .dec    (dec),
    .pc     (pc),
    .src1   (src1),
    .src2   (src2),
    .taken  (taken),
    .target (target),
    .link   (link)
  );

  // next result
  assign res_d.dest_enable          = dec.writes_dest;
  assign res_d.dest_long            = dec.writes_dest && !dec.word;
  // jumps write the return address
  assign res_d.dest                 = (dec.is_jal || dec.is_jalr) ? link : alu_result;
  assign res_d.branch_target_enable = taken;
  assign res_d.branch_target        = target;

  // single pipeline stage, new instruction every cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      res_q <= '0;
    else
      res_q <= res_d;
  end

  assign dest_enable          = res_q.dest_enable;
  assign dest_long            = res_q.dest_long;
  assign dest                 = res_q.dest;
  assign branch_target_enable = res_q.branch_target_enable;
  assign branch_target        = res_q.branch_target;

  // a long write is always a write
  assert property (@(posedge clk) disable iff (!arst_n) dest_long |-> dest_enable)
    else $error("dest_long without dest_enable");

endmodule

/* tb_core_alu.sv */
/*
  tb_core_alu
  vector-driven testbench for the one-cycle RV64I execution unit,
  vectors and expected outputs come from core_alu_input.txt
*/
`timescale 1ns/100ps

module tb_core_alu;

  localparam int clk_period = 100;
  localparam int fields     = 10;
  localparam int max_vecs   = 64;
  localparam int num_groups = 6;

  logic                     clk;
  logic                     arst_n;
  logic [31:0]              insn;
  logic [alu_pkg::xlen-1:0] pc;
  logic [alu_pkg::xlen-1:0] src1;
  logic [alu_pkg::xlen-1:0] src2;
  logic                     dest_enable;
  logic                     dest_long;
  logic [alu_pkg::xlen-1:0] dest;
  logic                     branch_target_enable;
  logic [alu_pkg::xlen-1:0] branch_target;

  // word 0 is the vector count, then fields words per vector
  logic [63:0] vec_mem [0:fields*max_vecs];
  int          num_vecs;
  bit          loaded;
  int          pass_count;
  int          fail_count;
  int          group_checks [0:num_groups-1];
  int          group_fails [0:num_groups-1];
  string       group_name [0:num_groups-1];

  core_alu u_core_alu (
    .clk                  (clk),
    .arst_n               (arst_n),
    .insn                 (insn),
    .pc                   (pc),
    .src1                 (src1),
    .src2                 (src2),
    .dest_enable          (dest_enable),
    .dest_long            (dest_long),
    .dest                 (dest),
    .branch_target_enable (branch_target_enable),
    .branch_target        (branch_target)
  );

  always #(clk_period/2) clk = ~clk;

  // first word of vector idx
  function automatic int base_of(input int idx);
    return 1 + idx * fields;
  endfunction

  function automatic int group_of(input int idx);
    int g;
    g = int'(vec_mem[base_of(idx)][7:0]);
    if (g >= num_groups)
      g = num_groups - 1;
    return g;
  endfunction

  task automatic check_value(input int g, input int idx, input string what,
                             input logic [63:0] got, input logic [63:0] exp);
    bit ok;
    ok = (got === exp);
    assert (ok)
      else $display("[FAIL] %0t ns: vector %0d %s is %h, expected %h",
                    $time, idx, what, got, exp);
    group_checks[g]++;
    if (ok) begin
      pass_count++;
    end else begin
      fail_count++;
      group_fails[g]++;
    end
  endtask

  // inputs change just after the rising edge
  task automatic apply_vector(input int idx);
    int b;
    b = base_of(idx);
    insn <= vec_mem[b+1][31:0];
    pc   <= vec_mem[b+2];
    src1 <= vec_mem[b+3];
    src2 <= vec_mem[b+4];
  endtask

  // dest and target only matter when their enable is expected
  task automatic check_vector(input int idx);
    int b;
    int g;
    b = base_of(idx);
    g = group_of(idx);
    check_value(g, idx, "dest_enable", 64'(dest_enable), vec_mem[b+5]);
    check_value(g, idx, "dest_long", 64'(dest_long), vec_mem[b+6]);
    if (vec_mem[b+5][0])
      check_value(g, idx, "dest", dest, vec_mem[b+7]);
    check_value(g, idx, "branch_target_enable", 64'(branch_target_enable), vec_mem[b+8]);
    if (vec_mem[b+8][0])
      check_value(g, idx, "branch_target", branch_target, vec_mem[b+9]);
  endtask

  task automatic report_group(input int g);
    $display("group %0d (%s): %0d checks, %0d failed",
             g, group_name[g], group_checks[g], group_fails[g]);
  endtask

  initial begin
    int g;
    clk        = 1'b0;
    arst_n     = 1'b0;
    // jal x0, 0 would raise both enables
    insn       = 32'h0000006f;
    pc         = '0;
    src1       = '0;
    src2       = '0;
    pass_count = 0;
    fail_count = 0;
    for (int k = 0; k < num_groups; k++) begin
      group_checks[k] = 0;
      group_fails[k]  = 0;
    end
    group_name[0] = "reset";
    group_name[1] = "64-bit register and immediate ops";
    group_name[2] = "word ops";
    group_name[3] = "auipc and jumps";
    group_name[4] = "conditional branches";
    group_name[5] = "unsupported and back-to-back";

    $readmemh("core_alu_input.txt", vec_mem);
    num_vecs = int'(vec_mem[0][15:0]);
    if (num_vecs < 1 || num_vecs > max_vecs) begin
      $display("could not read a valid vector count from core_alu_input.txt");
      fail_count++;
      num_vecs = 0;
    end
    loaded = 1'b1;

    // 8 reset cycles with the idle jal applied so only reset holds the enables low
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_value(0, -1, "dest_enable", 64'(dest_enable), 64'd0);
    check_value(0, -1, "branch_target_enable", 64'(branch_target_enable), 64'd0);
    report_group(0);

    // vector i goes in at edge n, its result is read after edge n+1
    for (int i = 0; i <= num_vecs; i++) begin
      @(posedge clk);
      if (i < num_vecs)
        apply_vector(i);
      @(negedge clk);
      if (i > 0) begin
        g = group_of(i - 1);
        check_vector(i - 1);
        if (i == num_vecs || group_of(i) != g)
          report_group(g);
      end
    end

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && pass_count > 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  // run length is reset plus one cycle per vector, 20 cycles of margin
  initial begin
    wait (loaded);
    #((num_vecs + 20) * clk_period);
    $display("timeout: the run did not end within %0d clock cycles", num_vecs + 20);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* core_alu_input.txt */
// columns: group insn pc src1 src2 dest_enable dest_long dest branch_target_enable branch_target
// all hex, first value is the number of vectors, unused dest and target are 0
29
// group 1, 64-bit ops: add sub sll slt sltu xor sra and addi slti slli srai
1 003100b3 1000 7fffffffffffffff 1 1 1 8000000000000000 0 0
1 403100b3 1000 5 7 1 1 fffffffffffffffe 0 0
1 003110b3 1000 1 43 1 1 8 0 0
1 003120b3 1000 ffffffffffffffff 1 1 1 1 0 0
1 003130b3 1000 ffffffffffffffff 1 1 1 0 0 0
1 003140b3 1000 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 1 1 0ff00ff00ff00ff0 0 0
1 403150b3 1000 8000000000000000 3c 1 1 fffffffffffffff8 0 0
1 003170b3 1000 ffff0000ffff0000 0f0f0f0f0f0f0f0f 1 1 0f0f00000f0f0000 0 0
1 fff10093 1000 0 dead 1 1 ffffffffffffffff 0 0
1 00512093 1000 fffffffffffffffb 0 1 1 1 0 0
1 02811093 1000 3 0 1 1 30000000000 0 0
1 42015093 1000 8765432100000000 0 1 1 ffffffff87654321 0 0
// group 2, word ops: addw subw sllw srlw sraw addiw slliw srliw sraiw
2 003100bb 1000 7fffffff 1 1 0 ffffffff80000000 0 0
2 403100bb 1000 1234567800000003 5 1 0 fffffffffffffffe 0 0
2 003110bb 1000 1 3f 1 0 ffffffff80000000 0 0
2 003150bb 1000 ffffffff80000000 4 1 0 8000000 0 0
2 403150bb 1000 80000000 4 1 0 fffffffff8000000 0 0
2 0011009b 1000 aaaaaaaa00000010 0 1 0 11 0 0
2 01f1109b 1000 3 0 1 0 ffffffff80000000 0 0
2 0041509b 1000 f0000000 0 1 0 f000000 0 0
2 4041509b 1000 f0000000 0 1 0 ffffffffff000000 0 0
// group 3, auipc up and down, jal forward and back, jalr with odd sum
3 12345097 1000 0 0 1 1 12346000 0 0
3 fffff097 80000000 0 0 1 1 7ffff000 0 0
3 100000ef 2000 0 0 1 1 2004 1 2100
3 ff9ff0ef 2000 0 0 1 1 2004 1 1ff8
3 ffd100e7 3000 4000 0 1 1 3004 1 3ffc
// group 4, each condition taken then not taken, one backward bne
4 00310863 5000 7 7 0 0 0 1 5010
4 00310863 5000 7 8 0 0 0 0 0
4 fe3110e3 5000 7 8 0 0 0 1 4fe0
4 00311863 5000 7 7 0 0 0 0 0
4 00314863 5000 ffffffffffffffff 1 0 0 0 1 5010
4 00314863 5000 1 ffffffffffffffff 0 0 0 0 0
4 00315863 5000 1 ffffffffffffffff 0 0 0 1 5010
4 00315863 5000 ffffffffffffffff 1 0 0 0 0 0
4 00316863 5000 1 ffffffffffffffff 0 0 0 1 5010
4 00316863 5000 ffffffffffffffff 1 0 0 0 0 0
4 00317863 5000 ffffffffffffffff 1 0 0 0 1 5010
4 00317863 5000 1 ffffffffffffffff 0 0 0 0 0
// group 5, load and mul encodings, then an add right after
5 00013083 1000 4000 0 0 0 0 0 0
5 023100b3 1000 2 3 0 0 0 0 0
5 003100b3 1000 2 3 1 1 5 0 0

/* build.f */
alu_pkg.sv
insn_decode.sv
int_alu.sv
branch_unit.sv
core_alu.sv
tb_core_alu.sv

/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/100ps
TOP        = tb_core_alu
FILELIST   = build.f
PASS_MSG   = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
